// File: rtl/csr_addr_pkg.sv
`default_nettype none

package csr_addr_pkg;

    localparam int CSR_DATA_W = 32;

    // Implemented CSR addresses
    typedef enum logic [11:0] {
        MVENDORID  = 12'hF11,
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MIP        = 12'h344,
        MCYCLE     = 12'hB00,
        MCYCLEH    = 12'hB80,
        // MVU configuration block
        MUL_MODE   = 12'h7C0,
        COUNTDOWN  = 12'h7C1,
        WPRECISION = 12'h7C2,
        IPRECISION = 12'h7C3,
        OPRECISION = 12'h7C4,
        WBASEADDR  = 12'h7C5,
        IBASEADDR  = 12'h7C6,
        OBASEADDR  = 12'h7C7
    } csr_addr_e;

    // Codes 5..7 decode as NONE
    typedef enum logic [2:0] {
        NONE  = 3'd0,
        WRITE = 3'd1,
        SET   = 3'd2,
        CLEAR = 3'd3,
        MRET  = 3'd4
    } csr_op_e;

endpackage

`default_nettype wire

// File: rtl/csr_field_pkg.sv
`default_nettype none

package csr_field_pkg;

    // ==============================
    // Interrupt bits, mip and mie
    // ==============================
    localparam int IRQ_M_SOFT  = 3;
    localparam int IRQ_M_TIMER = 7;
    localparam int IRQ_M_EXT   = 11;
    localparam int IRQ_MVU     = 16;

    localparam logic [31:0] MIE_WMASK = (32'd1 << IRQ_M_SOFT)
                                      | (32'd1 << IRQ_M_TIMER)
                                      | (32'd1 << IRQ_M_EXT)
                                      | (32'd1 << IRQ_MVU);

    // ==============================
    // mstatus
    // ==============================
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    // MIE, MPIE and MPP[12:11]
    localparam logic [31:0] MSTATUS_WMASK = 32'h0000_1888;

    // Trap vector sits this far above the boot address
    localparam logic [31:0] MTVEC_RST_OFFSET = 32'h0000_0040;

    // Identity
    localparam logic [31:0] ISA_CODE     = 32'h4000_1100;   // RV32IM
    localparam logic [31:0] PITO_MARCHID = 32'h0000_0050;

    // ==============================
    // MVU field widths
    // ==============================
    localparam int MVU_MODE_W  = 2;
    localparam int MVU_CNTDN_W = 29;
    localparam int MVU_PREC_W  = 6;
    localparam int MVU_WADDR_W = 9;    // Weight memory address
    localparam int MVU_DADDR_W = 15;   // Data memory address

endpackage

`default_nettype wire

// File: rtl/csr_access_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module csr_access_ctrl
    import csr_addr_pkg::*;
(
    input  csr_op_e                 csr_op_i,
    input  logic [CSR_DATA_W-1:0]   csr_wdata_i,
    // Machine bank
    input  logic [CSR_DATA_W-1:0]   mach_rdata_i,
    input  logic                    mach_rd_hit_i,
    input  logic                    mach_wr_ok_i,
    // MVU bank, always writable
    input  logic [CSR_DATA_W-1:0]   mvu_rdata_i,
    input  logic                    mvu_rd_hit_i,
    // To both banks
    output logic                    wr_en_o,
    output logic [CSR_DATA_W-1:0]   wr_data_o,
    output logic                    mret_o,
    // To the core
    output logic [CSR_DATA_W-1:0]   csr_rdata_o,
    output logic                    csr_illegal_o
);

    logic [CSR_DATA_W-1:0] cur_rdata;   // Value of the addressed register
    logic                  any_hit;

    assign any_hit   = mach_rd_hit_i | mvu_rd_hit_i;
    assign cur_rdata = mach_rd_hit_i ? mach_rdata_i :
                       mvu_rd_hit_i  ? mvu_rdata_i  : '0;

    // ==============================
    // Operation decode
    // ==============================
    always_comb begin
        wr_en_o   = 1'b0;
        mret_o    = 1'b0;
        wr_data_o = csr_wdata_i;
        case (csr_op_i)
            WRITE: wr_en_o = 1'b1;
            SET: begin
                wr_en_o   = 1'b1;
                wr_data_o = csr_wdata_i | cur_rdata;
            end
            CLEAR: begin
                wr_en_o   = 1'b1;
                wr_data_o = cur_rdata & ~csr_wdata_i;
            end
            MRET:    mret_o = 1'b1;   // No read or write side effect
            default: ;
        endcase
    end

    // Old value shows during the access, zero otherwise
    assign csr_rdata_o = wr_en_o ? cur_rdata : '0;

    // Unknown address, or a bank that refuses the write
    assign csr_illegal_o = wr_en_o & (~any_hit | (mach_rd_hit_i & ~mach_wr_ok_i));

    // A return must never also write a CSR in the same cycle
    always_comb begin
        op_excl_a: assert (!(wr_en_o && mret_o))
            else $error("csr_access_ctrl: write and mret together");
    end

endmodule

`default_nettype wire

// File: rtl/csr_machine_regs.sv
`timescale 1ns/100ps
`default_nettype none

module csr_machine_regs
    import csr_addr_pkg::*;
    import csr_field_pkg::*;
#(
    parameter int                    HART_ID   = 0,
    parameter logic [CSR_DATA_W-1:0] BOOT_ADDR = 32'h0000_1000
)(
    input  logic                    clk,
    input  logic                    rst_n,
    input  csr_addr_e               csr_addr_i,
    input  logic                    wr_en_i,
    input  logic [CSR_DATA_W-1:0]   wr_data_i,
    input  logic                    mret_i,
    input  logic                    irq_i,        // External
    input  logic                    time_irq_i,
    input  logic                    ipi_i,        // Software
    input  logic                    mvu_irq_i,
    input  logic                    enable_cycle_count_i,
    output logic [CSR_DATA_W-1:0]   rdata_o,
    output logic                    rd_hit_o,
    output logic                    wr_ok_o,
    output logic [CSR_DATA_W-1:0]   csr_epc_o
);

    logic [CSR_DATA_W-1:0] mstatus_q;
    logic [CSR_DATA_W-1:0] mie_q;
    logic [CSR_DATA_W-1:0] mip_q, mip_d;
    logic [CSR_DATA_W-1:0] mtvec_q, mtvec_wr;
    logic [CSR_DATA_W-1:0] mepc_q;
    logic [CSR_DATA_W-1:0] mcause_q;
    logic [63:0]           mcycle_q;

    // Pending bits straight from the interrupt lines
    always_comb begin
        mip_d              = '0;
        mip_d[IRQ_M_SOFT]  = ipi_i;
        mip_d[IRQ_M_TIMER] = time_irq_i;
        mip_d[IRQ_M_EXT]   = irq_i;
        mip_d[IRQ_MVU]     = mvu_irq_i;
    end

    // Vectored mode needs 256-byte alignment
    always_comb begin
        mtvec_wr = {wr_data_i[31:2], 1'b0, wr_data_i[0]};
        if (wr_data_i[0])
            mtvec_wr = {wr_data_i[31:8], 7'b0, wr_data_i[0]};
    end

    // ==============================
    // Register updates
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mip_q     <= '0;
            mtvec_q   <= BOOT_ADDR + MTVEC_RST_OFFSET;
            mepc_q    <= '0;
            mcause_q  <= '0;
            mcycle_q  <= '0;
        end else begin
            mip_q <= mip_d;

            // A write wins over counting
            if (wr_en_i && csr_addr_i == MCYCLE)
                mcycle_q <= {32'b0, wr_data_i};
            else if (wr_en_i && csr_addr_i == MCYCLEH)
                mcycle_q <= {wr_data_i, mcycle_q[31:0]};
            else if (enable_cycle_count_i)
                mcycle_q <= mcycle_q + 64'd1;

            if (mret_i) begin
                mstatus_q[MSTATUS_MIE]  <= mstatus_q[MSTATUS_MPIE];
                mstatus_q[MSTATUS_MPIE] <= 1'b1;
            end

            if (wr_en_i) begin
                case (csr_addr_i)
                    MSTATUS: mstatus_q <= wr_data_i & MSTATUS_WMASK;
                    MIE:     mie_q     <= wr_data_i & MIE_WMASK;
                    MTVEC:   mtvec_q   <= mtvec_wr;
                    MEPC:    mepc_q    <= {wr_data_i[31:1], 1'b0};
                    MCAUSE:  mcause_q  <= wr_data_i;
                    default: ;   // misa and mip ignore the data
                endcase
            end
        end
    end

    // ==============================
    // Read port and access rights
    // ==============================
    always_comb begin
        rdata_o  = '0;
        rd_hit_o = 1'b1;
        wr_ok_o  = 1'b1;
        case (csr_addr_i)
            MVENDORID: wr_ok_o = 1'b0;   // Reads zero
            MARCHID: begin
                rdata_o = PITO_MARCHID;
                wr_ok_o = 1'b0;
            end
            MIMPID:    wr_ok_o = 1'b0;
            MHARTID: begin
                rdata_o = CSR_DATA_W'(HART_ID);
                wr_ok_o = 1'b0;
            end
            MSTATUS: rdata_o = mstatus_q;
            MISA:    rdata_o = ISA_CODE;
            MIE:     rdata_o = mie_q;
            MTVEC:   rdata_o = mtvec_q;
            MEPC:    rdata_o = mepc_q;
            MCAUSE:  rdata_o = mcause_q;
            MIP:     rdata_o = mip_q;
            MCYCLE:  rdata_o = mcycle_q[31:0];
            MCYCLEH: rdata_o = mcycle_q[63:32];
            default: begin
                rd_hit_o = 1'b0;
                wr_ok_o  = 1'b0;
            end
        endcase
    end

    assign csr_epc_o = mepc_q;

    mepc_align_a: assert property (@(posedge clk) disable iff (!rst_n)
        mepc_q[0] == 1'b0);

    mie_mask_a: assert property (@(posedge clk) disable iff (!rst_n)
        (mie_q & ~MIE_WMASK) == '0);

endmodule

`default_nettype wire

// File: rtl/csr_mvu_regs.sv
`timescale 1ns/100ps
`default_nettype none

module csr_mvu_regs
    import csr_addr_pkg::*;
    import csr_field_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  csr_addr_e               csr_addr_i,
    input  logic                    wr_en_i,
    input  logic [CSR_DATA_W-1:0]   wr_data_i,
    output logic [CSR_DATA_W-1:0]   rdata_o,
    output logic                    rd_hit_o,
    // Configuration to the MVU
    output logic [MVU_MODE_W-1:0]   mvu_mul_mode_o,
    output logic [MVU_CNTDN_W-1:0]  mvu_countdown_o,
    output logic [MVU_PREC_W-1:0]   mvu_wprecision_o,
    output logic [MVU_PREC_W-1:0]   mvu_iprecision_o,
    output logic [MVU_PREC_W-1:0]   mvu_oprecision_o,
    output logic [MVU_WADDR_W-1:0]  mvu_wbaseaddr_o,
    output logic [MVU_DADDR_W-1:0]  mvu_ibaseaddr_o,
    output logic [MVU_DADDR_W-1:0]  mvu_obaseaddr_o
);

    // Each field keeps only its low bits of the written word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mvu_mul_mode_o   <= '0;
            mvu_countdown_o  <= '0;
            mvu_wprecision_o <= '0;
            mvu_iprecision_o <= '0;
            mvu_oprecision_o <= '0;
            mvu_wbaseaddr_o  <= '0;
            mvu_ibaseaddr_o  <= '0;
            mvu_obaseaddr_o  <= '0;
        end else if (wr_en_i) begin
            case (csr_addr_i)
                MUL_MODE:   mvu_mul_mode_o   <= wr_data_i[MVU_MODE_W-1:0];
                COUNTDOWN:  mvu_countdown_o  <= wr_data_i[MVU_CNTDN_W-1:0];
                WPRECISION: mvu_wprecision_o <= wr_data_i[MVU_PREC_W-1:0];
                IPRECISION: mvu_iprecision_o <= wr_data_i[MVU_PREC_W-1:0];
                OPRECISION: mvu_oprecision_o <= wr_data_i[MVU_PREC_W-1:0];
                WBASEADDR:  mvu_wbaseaddr_o  <= wr_data_i[MVU_WADDR_W-1:0];
                IBASEADDR:  mvu_ibaseaddr_o  <= wr_data_i[MVU_DADDR_W-1:0];
                OBASEADDR:  mvu_obaseaddr_o  <= wr_data_i[MVU_DADDR_W-1:0];
                default: ;
            endcase
        end
    end

    // ==============================
    // Read port, zero-extended
    // ==============================
    always_comb begin
        rdata_o  = '0;
        rd_hit_o = 1'b1;
        case (csr_addr_i)
            MUL_MODE:   rdata_o = CSR_DATA_W'(mvu_mul_mode_o);
            COUNTDOWN:  rdata_o = CSR_DATA_W'(mvu_countdown_o);
            WPRECISION: rdata_o = CSR_DATA_W'(mvu_wprecision_o);
            IPRECISION: rdata_o = CSR_DATA_W'(mvu_iprecision_o);
            OPRECISION: rdata_o = CSR_DATA_W'(mvu_oprecision_o);
            WBASEADDR:  rdata_o = CSR_DATA_W'(mvu_wbaseaddr_o);
            IBASEADDR:  rdata_o = CSR_DATA_W'(mvu_ibaseaddr_o);
            OBASEADDR:  rdata_o = CSR_DATA_W'(mvu_obaseaddr_o);
            default:    rd_hit_o = 1'b0;   // Not an MVU address
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/rv32_csr_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_csr_top
    import csr_addr_pkg::*;
    import csr_field_pkg::*;
#(
    parameter int                    HART_ID   = 0,
    parameter logic [CSR_DATA_W-1:0] BOOT_ADDR = 32'h0000_1000
)(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [11:0]             csr_addr_i,
    input  logic [2:0]              csr_op_i,
    input  logic [CSR_DATA_W-1:0]   csr_wdata_i,
    input  logic                    irq_i,
    input  logic                    time_irq_i,
    input  logic                    ipi_i,
    input  logic                    mvu_irq_i,
    input  logic                    enable_cycle_count_i,
    output logic [CSR_DATA_W-1:0]   csr_rdata_o,
    output logic                    csr_illegal_o,
    output logic [CSR_DATA_W-1:0]   csr_epc_o,
    output logic [MVU_MODE_W-1:0]   mvu_mul_mode_o,
    output logic [MVU_CNTDN_W-1:0]  mvu_countdown_o,
    output logic [MVU_PREC_W-1:0]   mvu_wprecision_o,
    output logic [MVU_PREC_W-1:0]   mvu_iprecision_o,
    output logic [MVU_PREC_W-1:0]   mvu_oprecision_o,
    output logic [MVU_WADDR_W-1:0]  mvu_wbaseaddr_o,
    output logic [MVU_DADDR_W-1:0]  mvu_ibaseaddr_o,
    output logic [MVU_DADDR_W-1:0]  mvu_obaseaddr_o
);

    csr_addr_e             csr_addr;
    csr_op_e               csr_op;
    logic                  wr_en, mret;
    logic [CSR_DATA_W-1:0] wr_data;
    logic [CSR_DATA_W-1:0] mach_rdata, mvu_rdata;
    logic                  mach_rd_hit, mach_wr_ok, mvu_rd_hit;

    assign csr_addr = csr_addr_e'(csr_addr_i);
    assign csr_op   = csr_op_e'(csr_op_i);

    csr_access_ctrl u_access_ctrl (
        .csr_op_i      (csr_op),
        .csr_wdata_i   (csr_wdata_i),
        .mach_rdata_i  (mach_rdata),
        .mach_rd_hit_i (mach_rd_hit),
        .mach_wr_ok_i  (mach_wr_ok),
        .mvu_rdata_i   (mvu_rdata),
        .mvu_rd_hit_i  (mvu_rd_hit),
        .wr_en_o       (wr_en),
        .wr_data_o     (wr_data),
        .mret_o        (mret),
        .csr_rdata_o   (csr_rdata_o),
        .csr_illegal_o (csr_illegal_o)
    );

    csr_machine_regs #(
        .HART_ID   (HART_ID),
        .BOOT_ADDR (BOOT_ADDR)
    ) u_machine_regs (
        .clk                  (clk),
        .rst_n                (rst_n),
        .csr_addr_i           (csr_addr),
        .wr_en_i              (wr_en),
        .wr_data_i            (wr_data),
        .mret_i               (mret),
        .irq_i                (irq_i),
        .time_irq_i           (time_irq_i),
        .ipi_i                (ipi_i),
        .mvu_irq_i            (mvu_irq_i),
        .enable_cycle_count_i (enable_cycle_count_i),
        .rdata_o              (mach_rdata),
        .rd_hit_o             (mach_rd_hit),
        .wr_ok_o              (mach_wr_ok),
        .csr_epc_o            (csr_epc_o)
    );

    csr_mvu_regs u_mvu_regs (
        .clk              (clk),
        .rst_n            (rst_n),
        .csr_addr_i       (csr_addr),
        .wr_en_i          (wr_en),
        .wr_data_i        (wr_data),
        .rdata_o          (mvu_rdata),
        .rd_hit_o         (mvu_rd_hit),
        .mvu_mul_mode_o   (mvu_mul_mode_o),
        .mvu_countdown_o  (mvu_countdown_o),
        .mvu_wprecision_o (mvu_wprecision_o),
        .mvu_iprecision_o (mvu_iprecision_o),
        .mvu_oprecision_o (mvu_oprecision_o),
        .mvu_wbaseaddr_o  (mvu_wbaseaddr_o),
        .mvu_ibaseaddr_o  (mvu_ibaseaddr_o),
        .mvu_obaseaddr_o  (mvu_obaseaddr_o)
    );

endmodule

`default_nettype wire

// File: sim/rv32_csr_tb_checks.svh
`ifndef RV32_CSR_TB_CHECKS_SVH
`define RV32_CSR_TB_CHECKS_SVH

// ==============================
// Error counters
// ==============================
int err_rd  = 0;
int err_ill = 0;
int err_epc = 0;
int err_mvu = 0;

// Read data shown during the access
rd_check_a: assert property (@(posedge clk) disable iff (!rst_n)
    chk_rd |-> (csr_rdata == exp_rd))
    else begin
        err_rd = err_rd + 1;
        $display("[FAIL] %s: expected %h, actual %h", test_name, exp_rd, $sampled(csr_rdata));
    end

ill_check_a: assert property (@(posedge clk) disable iff (!rst_n)
    chk_ill |-> (csr_illegal == exp_ill))
    else begin
        err_ill = err_ill + 1;
        $display("[FAIL] %s illegal: expected %b, actual %b", test_name, exp_ill,
                 $sampled(csr_illegal));
    end

epc_check_a: assert property (@(posedge clk) disable iff (!rst_n)
    chk_epc |-> (csr_epc == exp_epc))
    else begin
        err_epc = err_epc + 1;
        $display("[FAIL] %s epc: expected %h, actual %h", test_name, exp_epc, $sampled(csr_epc));
    end

// All eight MVU ports at once
mvu_check_a: assert property (@(posedge clk) disable iff (!rst_n)
    chk_mvu |-> (mvu_bus == exp_mvu))
    else begin
        err_mvu = err_mvu + 1;
        $display("[FAIL] %s ports: expected %h, actual %h", test_name, exp_mvu,
                 $sampled(mvu_bus));
    end

`endif

// File: sim/rv32_csr_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_csr_tb
    import csr_addr_pkg::*;
    import csr_field_pkg::*;
();

    localparam logic [31:0] HART_ID_DFLT   = 32'd0;          // DUT defaults
    localparam logic [31:0] BOOT_ADDR_DFLT = 32'h0000_1000;
    localparam int          CNT_CYCLES     = 10;
    localparam int          TIMEOUT_CYCLES = 400;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic [11:0] csr_addr = '0;
    logic [2:0]  csr_op = '0;
    logic [31:0] csr_wdata = '0;
    logic        irq = 1'b0, time_irq = 1'b0, ipi = 1'b0, mvu_irq = 1'b0;
    logic        enable_cycle_count = 1'b0;
    logic [31:0] csr_rdata, csr_epc;
    logic        csr_illegal;
    logic [1:0]  mvu_mul_mode;
    logic [28:0] mvu_countdown;
    logic [5:0]  mvu_wprecision, mvu_iprecision, mvu_oprecision;
    logic [8:0]  mvu_wbaseaddr;
    logic [14:0] mvu_ibaseaddr, mvu_obaseaddr;
    logic [87:0] mvu_bus;

    // Expected values recorded by the stimulus
    string       test_name = "";
    logic        chk_rd = 1'b0, chk_ill = 1'b0, chk_epc = 1'b0, chk_mvu = 1'b0;
    logic [31:0] exp_rd = '0, exp_epc = '0;
    logic        exp_ill = 1'b0;
    logic [87:0] exp_mvu = '0;
    logic [31:0] mvu_model [8] = '{default: '0};
    logic [31:0] mie_m = '0, mstatus_m = '0;
    logic [31:0] lcg_state = 32'd93;
    int          cycles = 0;
    int          errors;

    always #10 clk = ~clk;

    rv32_csr_top u_dut (
        .clk (clk), .rst_n (rst_n),
        .csr_addr_i (csr_addr), .csr_op_i (csr_op), .csr_wdata_i (csr_wdata),
        .irq_i (irq), .time_irq_i (time_irq), .ipi_i (ipi), .mvu_irq_i (mvu_irq),
        .enable_cycle_count_i (enable_cycle_count),
        .csr_rdata_o (csr_rdata), .csr_illegal_o (csr_illegal), .csr_epc_o (csr_epc),
        .mvu_mul_mode_o (mvu_mul_mode), .mvu_countdown_o (mvu_countdown),
        .mvu_wprecision_o (mvu_wprecision), .mvu_iprecision_o (mvu_iprecision),
        .mvu_oprecision_o (mvu_oprecision), .mvu_wbaseaddr_o (mvu_wbaseaddr),
        .mvu_ibaseaddr_o (mvu_ibaseaddr), .mvu_obaseaddr_o (mvu_obaseaddr)
    );

    assign mvu_bus = {mvu_mul_mode, mvu_countdown, mvu_wprecision, mvu_iprecision,
                      mvu_oprecision, mvu_wbaseaddr, mvu_ibaseaddr, mvu_obaseaddr};

    `include "rv32_csr_tb_checks.svh"

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [87:0] pack_mvu();
        return {mvu_model[0][1:0], mvu_model[1][28:0], mvu_model[2][5:0], mvu_model[3][5:0],
                mvu_model[4][5:0], mvu_model[5][8:0], mvu_model[6][14:0], mvu_model[7][14:0]};
    endfunction

    // ==============================
    // Access tasks
    // ==============================
    task automatic access(input string name, input logic [11:0] addr, input logic [2:0] op,
                          input logic [31:0] wdata, input logic rd_en,
                          input logic [31:0] rd_exp, input logic ill_exp);
        test_name = name;
        csr_addr  = addr;
        csr_op    = op;
        csr_wdata = wdata;
        chk_rd    = rd_en;
        exp_rd    = rd_exp;
        chk_ill   = 1'b1;
        exp_ill   = ill_exp;
        @(posedge clk);
        #1;
        chk_rd  = 1'b0;
        chk_ill = 1'b0;
        chk_epc = 1'b0;
        chk_mvu = 1'b0;
        csr_op  = NONE;
    endtask

    // Set with zero leaves the register as it is
    task automatic read_csr(input string name, input logic [11:0] addr,
                            input logic [31:0] rd_exp, input logic ill_exp);
        access(name, addr, SET, '0, 1'b1, rd_exp, ill_exp);
    endtask

    task automatic idle(input int n);
        csr_op = NONE;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic reset_values();
        chk_mvu = 1'b1;
        exp_mvu = '0;
        chk_epc = 1'b1;
        exp_epc = '0;
        read_csr("reset_mtvec", MTVEC, BOOT_ADDR_DFLT + 32'h40, 1'b0);
        read_csr("reset_mstatus", MSTATUS, '0, 1'b0);
        read_csr("reset_mie", MIE, '0, 1'b0);
        read_csr("reset_mepc", MEPC, '0, 1'b0);
        access("none_no_illegal", 12'h123, NONE, '0, 1'b1, '0, 1'b0);
    endtask

    task automatic mvu_write_readback();
        logic [11:0] addr [8];
        int          width [8];
        logic [31:0] word;
        addr  = '{MUL_MODE, COUNTDOWN, WPRECISION, IPRECISION,
                  OPRECISION, WBASEADDR, IBASEADDR, OBASEADDR};
        width = '{2, 29, 6, 6, 6, 9, 15, 15};
        for (int i = 0; i < 8; i++) begin
            word = next_rand();
            access($sformatf("mvu_write_%0d", i), addr[i], WRITE, word, 1'b1,
                   mvu_model[i], 1'b0);
            mvu_model[i] = word & ((32'd1 << width[i]) - 32'd1);   // Field width only
            chk_mvu = 1'b1;
            exp_mvu = pack_mvu();
            read_csr($sformatf("mvu_readback_%0d", i), addr[i], mvu_model[i], 1'b0);
        end
    endtask

    task automatic set_clear_mret();
        logic [31:0] w;
        w = next_rand();
        access("mie_set", MIE, SET, w, 1'b1, mie_m, 1'b0);
        mie_m = (mie_m | w) & 32'h0001_0888;                      // Bits 3, 7, 11, 16
        w = next_rand();
        access("mie_clear", MIE, CLEAR, w, 1'b1, mie_m, 1'b0);
        mie_m = mie_m & ~w;
        read_csr("mie_read", MIE, mie_m, 1'b0);
        w = next_rand();
        access("mstatus_set", MSTATUS, SET, w, 1'b1, mstatus_m, 1'b0);
        mstatus_m = (mstatus_m | w) & 32'h0000_1888;              // MIE, MPIE, MPP
        w = next_rand();
        access("mstatus_clear", MSTATUS, CLEAR, w, 1'b1, mstatus_m, 1'b0);
        mstatus_m = mstatus_m & ~w;
        // MPIE=1 and MIE=0 before the machine return
        access("mstatus_write", MSTATUS, WRITE, 32'h80, 1'b1, mstatus_m, 1'b0);
        access("mret_op", MSTATUS, MRET, '0, 1'b1, '0, 1'b0);
        read_csr("mret_mstatus", MSTATUS, 32'h88, 1'b0);
        w = next_rand() | 32'd1;
        access("mepc_write", MEPC, WRITE, w, 1'b1, '0, 1'b0);
        chk_epc = 1'b1;
        exp_epc = w & ~32'd1;
        read_csr("mepc_read", MEPC, w & ~32'd1, 1'b0);
    endtask

    task automatic access_legality();
        logic [31:0] w;
        w = next_rand();
        access("unknown_write", 12'h123, WRITE, w, 1'b1, '0, 1'b1);
        access("unknown_set", 12'h123, SET, w, 1'b1, '0, 1'b1);
        access("unknown_clear", 12'h123, CLEAR, w, 1'b1, '0, 1'b1);
        access("mhartid_write", MHARTID, WRITE, w, 1'b1, HART_ID_DFLT, 1'b1);
        access("marchid_write", MARCHID, WRITE, w, 1'b1, PITO_MARCHID, 1'b1);
        access("misa_write", MISA, WRITE, w, 1'b1, 32'h4000_1100, 1'b0);
        read_csr("misa_read", MISA, 32'h4000_1100, 1'b0);
        read_csr("mhartid_read", MHARTID, HART_ID_DFLT, 1'b1);
    endtask

    task automatic counter_and_irq();
        logic [31:0] start;
        logic [63:0] count;
        start = next_rand();
        access("mcycle_write", MCYCLE, WRITE, start, 1'b1, '0, 1'b0);
        enable_cycle_count = 1'b1;
        idle(CNT_CYCLES);
        enable_cycle_count = 1'b0;
        count = {32'd0, start} + 64'(CNT_CYCLES);
        read_csr("mcycleh_read", MCYCLEH, count[63:32], 1'b0);
        read_csr("mcycle_read", MCYCLE, count[31:0], 1'b0);
        ipi     = 1'b1;
        mvu_irq = 1'b1;
        read_csr("mip_same_cycle", MIP, '0, 1'b0);
        ipi      = 1'b0;
        mvu_irq  = 1'b0;
        time_irq = 1'b1;
        irq      = 1'b1;
        read_csr("mip_soft_mvu", MIP, (32'd1 << 3) | (32'd1 << 16), 1'b0);
        time_irq = 1'b0;
        irq      = 1'b0;
        read_csr("mip_timer_ext", MIP, (32'd1 << 7) | (32'd1 << 11), 1'b0);
    endtask

    // ==============================
    // Run and report
    // ==============================
    initial begin
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_values();
        mvu_write_readback();
        set_clear_mret();
        access_legality();
        counter_and_irq();
        idle(2);
        errors = err_rd + err_ill + err_epc + err_mvu;
        $display("Errors: rdata %0d, illegal %0d, epc %0d, mvu %0d, total %0d",
                 err_rd, err_ill, err_epc, err_mvu, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the stimulus did not finish", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+sim
rtl/csr_addr_pkg.sv
rtl/csr_field_pkg.sv
rtl/csr_access_ctrl.sv
rtl/csr_machine_regs.sv
rtl/csr_mvu_regs.sv
rtl/rv32_csr_top.sv
sim/rv32_csr_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv32_csr_tb
RTL_TOP   ?= rv32_csr_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
